//--- logic/rvc_pkg.sv
package rvc_pkg;

    // datapath widths
    localparam int INST_W = 32;
    localparam int HALF_W = 16;
    localparam int ADDR_W = 32;
    localparam int REG_W  = 5;

    // rv32i major opcodes
    localparam logic [6:0] OP_ARITH  = 7'b0110011;
    localparam logic [6:0] OP_ARITHI = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // funct3 codes, add doubles as sub
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 for sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // low two bits of a fetch word
    localparam logic [1:0] Q0     = 2'b00;
    localparam logic [1:0] Q1     = 2'b01;
    localparam logic [1:0] Q2     = 2'b10;
    localparam logic [1:0] Q_FULL = 2'b11;

    // fixed registers
    localparam logic [REG_W-1:0] REG_ZERO  = 5'd0;
    localparam logic [REG_W-1:0] REG_RA    = 5'd1;
    localparam logic [REG_W-1:0] REG_SP    = 5'd2;
    // rd'/rs1'/rs2' map onto x8..x15
    localparam logic [REG_W-1:0] CREG_BASE = 5'd8;

    typedef enum logic [4:0] {
        KIND_ADD, KIND_SUB, KIND_XOR, KIND_OR, KIND_AND,
        KIND_JR, KIND_MV, KIND_JALR, KIND_SWSP, KIND_LI,
        KIND_ADDI16SP, KIND_LUI, KIND_SRLI, KIND_SRAI, KIND_ANDI,
        KIND_ADDI, KIND_SLLI, KIND_LWSP, KIND_ADDI4SPN, KIND_LW,
        KIND_SW, KIND_BEQZ, KIND_BNEZ, KIND_JAL, KIND_J,
        KIND_ILLEGAL
    } rvc_kind_e;

    // one 16-bit half seen through each compressed format
    typedef union packed {
        struct packed {
            logic [3:0] funct4;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] op;
        } cr;
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;
            logic [4:0] rd_rs1;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } ci;
        struct packed {
            logic [2:0] funct3;
            logic [5:0] imm;
            logic [4:0] rs2;
            logic [1:0] op;
        } css;
        struct packed {
            logic [2:0] funct3;
            logic [7:0] imm;
            logic [2:0] rdp;
            logic [1:0] op;
        } ciw;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1p;
            logic [1:0] imm_lo;
            logic [2:0] rdp_rs2p;
            logic [1:0] op;
        } cl_cs;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] off_hi;
            logic [2:0] rs1p;
            logic [4:0] off_lo;
            logic [1:0] op;
        } cb;
        struct packed {
            logic [2:0]  funct3;
            logic [10:0] target;
            logic [1:0]  op;
        } cj;
    } rvc_half_u;

    typedef struct packed {
        logic [INST_W-1:0] inst;
        logic [ADDR_W-1:0] pc;
        logic              predict_jump;
    } fetch_slot_t;

    typedef struct packed {
        rvc_kind_e        kind;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
    } rvc_fields_t;

endpackage

//--- logic/rvc_field_decode.sv
`timescale 1ns/100ps

module rvc_field_decode import rvc_pkg::*; (
    input  rvc_half_u   half,
    output rvc_fields_t fields
);

    // compact register to full register number
    function automatic logic [REG_W-1:0] creg(input logic [2:0] r);
        return {2'b00, r} + CREG_BASE;
    endfunction

    always_comb begin
        fields.kind = KIND_ILLEGAL;
        fields.rd   = REG_ZERO;
        fields.rs1  = REG_ZERO;
        fields.rs2  = REG_ZERO;
        case (half.cr.op)
            Q0: begin
                case (half.ciw.funct3)
                    3'b000: begin
                        fields.kind = KIND_ADDI4SPN;
                        fields.rd   = creg(half.ciw.rdp);
                        fields.rs1  = REG_SP;
                    end
                    3'b010: begin
                        fields.kind = KIND_LW;
                        fields.rd   = creg(half.cl_cs.rdp_rs2p);
                        fields.rs1  = creg(half.cl_cs.rs1p);
                    end
                    3'b110: begin
                        fields.kind = KIND_SW;
                        fields.rs1  = creg(half.cl_cs.rs1p);
                        fields.rs2  = creg(half.cl_cs.rdp_rs2p);
                    end
                    default: ;
                endcase
            end
            Q1: begin
                case (half.ci.funct3)
                    3'b000: fields.kind = KIND_ADDI;
                    3'b001: fields.kind = KIND_JAL;
                    3'b010: fields.kind = KIND_LI;
                    // rd field of x2 selects addi16sp over lui
                    3'b011: fields.kind = (half.ci.rd_rs1 == REG_SP) ? KIND_ADDI16SP : KIND_LUI;
                    3'b100: begin
                        case (half.cb.off_hi[1:0])
                            2'b00: fields.kind = KIND_SRLI;
                            2'b01: fields.kind = KIND_SRAI;
                            2'b10: fields.kind = KIND_ANDI;
                            default: begin
                                // register-register ops need bit 12 clear
                                if (!half.cb.off_hi[2]) begin
                                    case (half.cb.off_lo[4:3])
                                        2'b00:   fields.kind = KIND_SUB;
                                        2'b01:   fields.kind = KIND_XOR;
                                        2'b10:   fields.kind = KIND_OR;
                                        default: fields.kind = KIND_AND;
                                    endcase
                                end
                            end
                        endcase
                        fields.rd  = creg(half.cb.rs1p);
                        fields.rs1 = creg(half.cb.rs1p);
                        fields.rs2 = creg(half.cl_cs.rdp_rs2p);
                    end
                    3'b101: fields.kind = KIND_J;
                    3'b110: fields.kind = KIND_BEQZ;
                    default: fields.kind = KIND_BNEZ;
                endcase
                // ci forms work in place on rd
                if (half.ci.funct3 == 3'b000 || half.ci.funct3 == 3'b010 ||
                    half.ci.funct3 == 3'b011) begin
                    fields.rd  = half.ci.rd_rs1;
                    fields.rs1 = (half.ci.funct3 == 3'b010) ? REG_ZERO : half.ci.rd_rs1;
                end
                // branches compare rs1' against x0
                if (half.cb.funct3[2:1] == 2'b11) begin
                    fields.rs1 = creg(half.cb.rs1p);
                end
                // c.jal links to ra, c.j discards the link
                if (half.cj.funct3 == 3'b001) begin
                    fields.rd = REG_RA;
                end
            end
            Q2: begin
                case (half.ci.funct3)
                    3'b000: begin
                        fields.kind = KIND_SLLI;
                        fields.rd   = half.ci.rd_rs1;
                        fields.rs1  = half.ci.rd_rs1;
                    end
                    3'b010: begin
                        fields.kind = KIND_LWSP;
                        fields.rd   = half.ci.rd_rs1;
                        fields.rs1  = REG_SP;
                    end
                    3'b100: begin
                        // bit 12 and rs2 == 0 split jr, mv, jalr and add
                        case ({half.cr.funct4[0], half.cr.rs2 == REG_ZERO})
                            2'b01: begin
                                if (half.cr.rd_rs1 != REG_ZERO) begin
                                    fields.kind = KIND_JR;
                                end
                                fields.rs1 = half.cr.rd_rs1;
                            end
                            2'b00: begin
                                fields.kind = KIND_MV;
                                fields.rd   = half.cr.rd_rs1;
                                fields.rs2  = half.cr.rs2;
                            end
                            2'b11: begin
                                fields.kind = KIND_JALR;
                                fields.rd   = REG_RA;
                                fields.rs1  = half.cr.rd_rs1;
                            end
                            default: begin
                                fields.kind = KIND_ADD;
                                fields.rd   = half.cr.rd_rs1;
                                fields.rs1  = half.cr.rd_rs1;
                                fields.rs2  = half.cr.rs2;
                            end
                        endcase
                    end
                    3'b110: begin
                        fields.kind = KIND_SWSP;
                        fields.rs1  = REG_SP;
                        fields.rs2  = half.css.rs2;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- logic/rvc_imm_unscramble.sv
`timescale 1ns/100ps

module rvc_imm_unscramble import rvc_pkg::*; (
    input  rvc_half_u         half,
    input  rvc_kind_e         kind,
    output logic [INST_W-1:0] imm
);

    // ci immediate bits, bit 12 on top
    logic       ci_hi;
    logic [4:0] ci_lo;
    // cj target, t[0] is inst bit 2
    logic [10:0] t;

    assign ci_hi = half.ci.imm_hi;
    assign ci_lo = half.ci.imm_lo;
    assign t     = half.cj.target;

    always_comb begin
        imm = '0;
        case (kind)
            // 6-bit signed
            KIND_ADDI, KIND_LI, KIND_ANDI: imm = {{26{ci_hi}}, ci_hi, ci_lo};
            // shift amounts, unsigned
            KIND_SLLI, KIND_SRLI, KIND_SRAI: imm = {26'b0, ci_hi, ci_lo};
            // nzimm[9|4|6|8:7|5], scaled by 16
            KIND_ADDI16SP: begin
                imm = {{22{ci_hi}}, ci_hi, ci_lo[2:1], ci_lo[3], ci_lo[0], ci_lo[4], 4'b0};
            end
            // upper immediate lands in bits 17:12
            KIND_LUI: imm = {{14{ci_hi}}, ci_hi, ci_lo, 12'b0};
            // uimm[5|4:2|7:6], word scaled
            KIND_LWSP: imm = {24'b0, ci_lo[1:0], ci_hi, ci_lo[4:2], 2'b0};
            // uimm[5:2|7:6]
            KIND_SWSP: imm = {24'b0, half.css.imm[1:0], half.css.imm[5:2], 2'b0};
            // nzuimm[5:4|9:6|2|3]
            KIND_ADDI4SPN: begin
                imm = {22'b0, half.ciw.imm[5:2], half.ciw.imm[7:6],
                       half.ciw.imm[0], half.ciw.imm[1], 2'b0};
            end
            KIND_LW, KIND_SW: begin
                imm = {25'b0, half.cl_cs.imm_lo[0], half.cl_cs.imm_hi,
                       half.cl_cs.imm_lo[1], 2'b0};
            end
            // offset[8|4:3] and [7:6|2:1|5], halfword scaled
            KIND_BEQZ, KIND_BNEZ: begin
                imm = {{23{half.cb.off_hi[2]}}, half.cb.off_hi[2], half.cb.off_lo[4:3],
                       half.cb.off_lo[0], half.cb.off_hi[1:0], half.cb.off_lo[2:1], 1'b0};
            end
            // offset[11|4|9:8|10|6|7|3:1|5]
            KIND_JAL, KIND_J: begin
                imm = {{20{t[10]}}, t[10], t[6], t[8:7], t[4], t[5], t[0], t[9],
                       t[3:1], 1'b0};
            end
            // register forms and jr/jalr carry no immediate
            default: imm = '0;
        endcase
    end

endmodule

//--- logic/rvc_rv32_encode.sv
`timescale 1ns/100ps

module rvc_rv32_encode import rvc_pkg::*; (
    input  rvc_fields_t       fields,
    input  logic [INST_W-1:0] imm,
    output logic [INST_W-1:0] inst32
);

    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;

    assign rd  = fields.rd;
    assign rs1 = fields.rs1;
    assign rs2 = fields.rs2;

    always_comb begin
        inst32 = '0;
        case (fields.kind)
            // R-type
            KIND_ADD, KIND_MV: begin
                inst32 = {7'b0, rs2, rs1, F3_ADD, rd, OP_ARITH};
            end
            KIND_SUB: inst32 = {F7_ALT, rs2, rs1, F3_ADD, rd, OP_ARITH};
            KIND_XOR: inst32 = {7'b0, rs2, rs1, F3_XOR, rd, OP_ARITH};
            KIND_OR:  inst32 = {7'b0, rs2, rs1, F3_OR, rd, OP_ARITH};
            KIND_AND: inst32 = {7'b0, rs2, rs1, F3_AND, rd, OP_ARITH};
            // jalr with zero offset, funct3 000
            KIND_JR, KIND_JALR: begin
                inst32 = {imm[11:0], rs1, 3'b000, rd, OP_JALR};
            end
            // I-type alu
            KIND_ADDI, KIND_LI, KIND_ADDI16SP, KIND_ADDI4SPN: begin
                inst32 = {imm[11:0], rs1, F3_ADD, rd, OP_ARITHI};
            end
            KIND_ANDI: inst32 = {imm[11:0], rs1, F3_AND, rd, OP_ARITHI};
            // shifts, shamt only in low five bits
            KIND_SLLI: inst32 = {7'b0, imm[4:0], rs1, F3_SLL, rd, OP_ARITHI};
            KIND_SRLI: inst32 = {7'b0, imm[4:0], rs1, F3_SR, rd, OP_ARITHI};
            KIND_SRAI: inst32 = {F7_ALT, imm[4:0], rs1, F3_SR, rd, OP_ARITHI};
            // U-type, upper 20 bits sign extended
            KIND_LUI: inst32 = {imm[31:12], rd, OP_LUI};
            // loads
            KIND_LW, KIND_LWSP: begin
                inst32 = {imm[11:0], rs1, F3_LW, rd, OP_LOAD};
            end
            // S-type split immediate
            KIND_SW, KIND_SWSP: begin
                inst32 = {imm[11:5], rs2, rs1, F3_LW, imm[4:0], OP_STORE};
            end
            // B-type
            KIND_BEQZ: begin
                inst32 = {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OP_BRANCH};
            end
            KIND_BNEZ: begin
                inst32 = {imm[12], imm[10:5], rs2, rs1, F3_BNE, imm[4:1], imm[11], OP_BRANCH};
            end
            // J-type, full offset layout
            KIND_JAL, KIND_J: begin
                inst32 = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
            end
            // unlisted pattern
            default: inst32 = '0;
        endcase
    end

endmodule

//--- logic/rvc_expand_ctrl.sv
`timescale 1ns/100ps

module rvc_expand_ctrl import rvc_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              rollback,
    input  logic              inst_valid,
    input  fetch_slot_t       slot_in,
    input  logic [INST_W-1:0] inst32,
    output rvc_half_u         half,
    output logic              out_valid,
    output fetch_slot_t       slot_out,
    output logic              is_c_extend
);

    logic accept;
    logic compressed;

    // low half goes to the decoder
    assign half       = slot_in.inst[HALF_W-1:0];
    assign compressed = (slot_in.inst[1:0] != Q_FULL);
    assign accept     = inst_valid && rdy && !rollback;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            is_c_extend <= 1'b0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                is_c_extend <= compressed;
            end
        end
    end

    // payload holds its last value between items
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_out.inst         <= compressed ? inst32 : slot_in.inst;
            slot_out.pc           <= slot_in.pc;
            slot_out.predict_jump <= slot_in.predict_jump;
        end
    end

    // nothing leaves the stage right after reset or a flush
    assert property (@(posedge clk) rst |=> !out_valid);
    assert property (@(posedge clk) disable iff (rst) rollback |=> !out_valid);

endmodule

//--- logic/rvc_expander.sv
`timescale 1ns/100ps

module rvc_expander import rvc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,
    input  logic        rollback,
    input  logic        inst_valid,
    input  fetch_slot_t slot_in,
    output logic        out_valid,
    output fetch_slot_t slot_out,
    output logic        is_c_extend
);

    rvc_half_u         half;
    rvc_fields_t       fields;
    logic [INST_W-1:0] imm;
    logic [INST_W-1:0] inst32;

    // control and output register
    rvc_expand_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .rollback    (rollback),
        .inst_valid  (inst_valid),
        .slot_in     (slot_in),
        .inst32      (inst32),
        .half        (half),
        .out_valid   (out_valid),
        .slot_out    (slot_out),
        .is_c_extend (is_c_extend)
    );

    // combinational expansion path
    rvc_field_decode u_decode (
        .half   (half),
        .fields (fields)
    );

    rvc_imm_unscramble u_imm (
        .half (half),
        .kind (fields.kind),
        .imm  (imm)
    );

    rvc_rv32_encode u_encode (
        .fields (fields),
        .imm    (imm),
        .inst32 (inst32)
    );

endmodule

//--- bench/rvc_ref_model.svh
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// expected rv32i word for one fetch word, written from the isa tables
function automatic logic [31:0] expand_reference(input logic [31:0] w);
    logic [15:0] h;
    logic [4:0]  rd_f;
    logic [4:0]  rs2_f;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] i6;
    logic [11:0] imm12;
    logic [11:0] joff;
    logic [20:0] j21;
    logic [12:0] b13;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] r;
    h     = w[15:0];
    rd_f  = h[11:7];
    rs2_f = h[6:2];
    // compact registers live in x8..x15
    rdp   = {2'b01, h[4:2]};
    rs1p  = {2'b01, h[9:7]};
    i6    = {{6{h[12]}}, h[12], h[6:2]};
    // jump offset [11|4|9:8|10|6|7|3:1|5]
    joff  = {h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    j21   = {{9{h[12]}}, joff};
    // branch offset [8|4:3] and [7:6|2:1|5]
    b13   = {{4{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
    r     = 32'h0;
    if (w[1:0] == 2'b11) begin
        r = w;
    end else begin
        case ({h[15:13], h[1:0]})
            // addi4spn, nzuimm[5:4|9:6|2|3]
            5'b000_00: r = {2'b00, h[10:7], h[12:11], h[5], h[6], 2'b00, 5'd2, 3'b000,
                            rdp, 7'b0010011};
            5'b010_00: r = {5'b0, h[5], h[12:10], h[6], 2'b00, rs1p, 3'b010, rdp, 7'b0000011};
            5'b110_00: begin
                imm12 = {5'b0, h[5], h[12:10], h[6], 2'b00};
                r = {imm12[11:5], rdp, rs1p, 3'b010, imm12[4:0], 7'b0100011};
            end
            5'b000_01: r = {i6, rd_f, 3'b000, rd_f, 7'b0010011};
            5'b001_01: r = {j21[20], j21[10:1], j21[11], j21[19:12], 5'd1, 7'b1101111};
            5'b010_01: r = {i6, 5'd0, 3'b000, rd_f, 7'b0010011};
            5'b011_01: begin
                if (rd_f == 5'd2) begin
                    // nzimm[9|4|6|8:7|5], sixteen-byte steps
                    imm12 = {{3{h[12]}}, h[4:3], h[5], h[2], h[6], 4'b0};
                    r = {imm12, 5'd2, 3'b000, 5'd2, 7'b0010011};
                end else begin
                    r = {{14{h[12]}}, h[12], h[6:2], rd_f, 7'b0110111};
                end
            end
            5'b100_01: begin
                case (h[11:10])
                    2'b00: r = {7'b0, h[6:2], rs1p, 3'b101, rs1p, 7'b0010011};
                    2'b01: r = {7'b0100000, h[6:2], rs1p, 3'b101, rs1p, 7'b0010011};
                    2'b10: r = {i6, rs1p, 3'b111, rs1p, 7'b0010011};
                    default: begin
                        f7 = (h[6:5] == 2'b00) ? 7'b0100000 : 7'b0;
                        case (h[6:5])
                            2'b00:   f3 = 3'b000;
                            2'b01:   f3 = 3'b100;
                            2'b10:   f3 = 3'b110;
                            default: f3 = 3'b111;
                        endcase
                        // bit 12 set here is not a listed form
                        r = h[12] ? 32'h0 : {f7, rdp, rs1p, f3, rs1p, 7'b0110011};
                    end
                endcase
            end
            5'b101_01: r = {j21[20], j21[10:1], j21[11], j21[19:12], 5'd0, 7'b1101111};
            5'b110_01: r = {b13[12], b13[10:5], 5'd0, rs1p, 3'b000, b13[4:1], b13[11],
                            7'b1100011};
            5'b111_01: r = {b13[12], b13[10:5], 5'd0, rs1p, 3'b001, b13[4:1], b13[11],
                            7'b1100011};
            5'b000_10: r = {7'b0, h[6:2], rd_f, 3'b001, rd_f, 7'b0010011};
            5'b010_10: r = {4'b0, h[3:2], h[12], h[6:4], 2'b00, 5'd2, 3'b010, rd_f, 7'b0000011};
            5'b100_10: begin
                if (!h[12] && rs2_f == 5'd0) begin
                    r = (rd_f == 5'd0) ? 32'h0 : {12'b0, rd_f, 3'b000, 5'd0, 7'b1100111};
                end else if (!h[12]) begin
                    r = {7'b0, rs2_f, 5'd0, 3'b000, rd_f, 7'b0110011};
                end else if (rs2_f == 5'd0) begin
                    r = {12'b0, rd_f, 3'b000, 5'd1, 7'b1100111};
                end else begin
                    r = {7'b0, rs2_f, rd_f, 3'b000, rd_f, 7'b0110011};
                end
            end
            5'b110_10: begin
                imm12 = {4'b0, h[8:7], h[12:9], 2'b00};
                r = {imm12[11:5], rs2_f, 5'd2, 3'b010, imm12[4:0], 7'b0100011};
            end
            default: r = 32'h0;
        endcase
    end
    return r;
endfunction

`endif

//--- bench/rvc_expander_tb.sv
`timescale 1ns/100ps

module rvc_expander_tb import rvc_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        rollback;
    logic        inst_valid;
    fetch_slot_t slot_in;
    logic        out_valid;
    fetch_slot_t slot_out;
    logic        is_c_extend;

    // last cycle's inputs as expected outputs
    logic        exp_valid = 1'b0;
    fetch_slot_t exp_slot  = '0;
    logic        exp_c     = 1'b0;

    int value_errors   = 0;
    int timeout_errors = 0;
    int checked        = 0;

    logic [31:0] lfsr_state;

    `include "rvc_ref_model.svh"

    rvc_expander UUT (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .rollback    (rollback),
        .inst_valid  (inst_valid),
        .slot_in     (slot_in),
        .out_valid   (out_valid),
        .slot_out    (slot_out),
        .is_c_extend (is_c_extend)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // force the fixed bits of one listed form onto random fields
    function automatic logic [15:0] make_form(input int k, input logic [15:0] r);
        logic [15:0] h;
        logic [31:0] fix;
        // upper half is the mask of fixed bits, lower half their values
        case (k)
            0:  fix = {16'hF003, 16'h9002};
            1:  fix = {16'hFC63, 16'h8C01};
            2:  fix = {16'hFC63, 16'h8C21};
            3:  fix = {16'hFC63, 16'h8C41};
            4:  fix = {16'hFC63, 16'h8C61};
            5:  fix = {16'hF07F, 16'h8002};
            6:  fix = {16'hF003, 16'h8002};
            7:  fix = {16'hF07F, 16'h9002};
            8:  fix = {16'hE003, 16'hC002};
            9:  fix = {16'hE003, 16'h4001};
            10: fix = {16'hEF83, 16'h6101};
            11: fix = {16'hE003, 16'h6001};
            12: fix = {16'hEC03, 16'h8001};
            13: fix = {16'hEC03, 16'h8401};
            14: fix = {16'hEC03, 16'h8801};
            15: fix = {16'hE003, 16'h0001};
            16: fix = {16'hE003, 16'h0002};
            17: fix = {16'hE003, 16'h4002};
            18: fix = {16'hE003, 16'h0000};
            19: fix = {16'hE003, 16'h4000};
            20: fix = {16'hE003, 16'hC000};
            21: fix = {16'hE003, 16'hC001};
            22: fix = {16'hE003, 16'hE001};
            23: fix = {16'hE003, 16'h2001};
            default: fix = {16'hE003, 16'hA001};
        endcase
        h = (r & ~fix[31:16]) | fix[15:0];
        // add and mv need a nonzero rs2
        if (k == 0 || k == 6) begin
            h[2] = h[2] | (h[6:3] == 0);
        end
        // jr needs a nonzero rs1
        if (k == 5) begin
            h[7] = h[7] | (h[11:8] == 0);
        end
        // rd of x2 would turn lui into addi16sp
        if (k == 11) begin
            h[8] = h[8] | (h[11:7] == 5'd2);
        end
        return h;
    endfunction

    // compressed patterns outside the listed forms
    function automatic logic [15:0] make_illegal(input int k, input logic [15:0] r);
        logic [15:0] h;
        h = r;
        case (k % 5)
            // q0 float loads and stores
            0:  begin
                h[15:13] = 3'b001;
                h[1:0]   = 2'b00;
            end
            1:  begin
                h[15:13] = 3'b101;
                h[1:0]   = 2'b00;
            end
            // rv64 subw/addw slot
            2:  begin
                h[15:10] = 6'b100111;
                h[1:0]   = 2'b01;
            end
            3:  begin
                h[15:13] = 3'b011;
                h[1:0]   = 2'b10;
            end
            // jr with x0
            default: h = 16'h8002;
        endcase
        return h;
    endfunction

    task automatic drive_item(input logic [31:0] inst, input logic v, input logic r,
                              input logic rb);
        logic [31:0] pc_bits;
        logic [31:0] pj;
        draw_bits(31, pc_bits);
        draw_bits(1, pj);
        @(posedge clk);
        inst_valid            <= v;
        rdy                   <= r;
        rollback              <= rb;
        slot_in.inst          <= inst;
        slot_in.pc            <= {pc_bits[30:0], 1'b0};
        slot_in.predict_jump  <= pj[0];
    endtask

    // output must go quiet within limit cycles
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (out_valid !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (out_valid !== 1'b0) begin
            timeout_errors++;
            $display("timeout: out_valid did not go low within %0d cycles", limit);
        end
    endtask

    // same accept rule as a fetch stage sees it
    always @(posedge clk) begin
        exp_valid <= !rst && inst_valid && rdy && !rollback;
        if (inst_valid && rdy && !rollback) begin
            exp_slot.inst         <= expand_reference(slot_in.inst);
            exp_slot.pc           <= slot_in.pc;
            exp_slot.predict_jump <= slot_in.predict_jump;
            exp_c                 <= (slot_in.inst[1:0] != 2'b11);
        end
        if (exp_valid && !rst) begin
            checked <= checked + 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) out_valid == exp_valid)
    else begin
        value_errors++;
        $display("ERR %0t out_valid exp %b got %b", $time, $sampled(exp_valid),
                 $sampled(out_valid));
    end

    assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        value_errors++;
        $display("ERR %0t out_valid after reset exp 0 got %b", $time, $sampled(out_valid));
    end

    assert property (@(posedge clk) rst |=> !is_c_extend)
    else begin
        value_errors++;
        $display("ERR %0t is_c_extend after reset exp 0 got %b", $time,
                 $sampled(is_c_extend));
    end

    assert property (@(posedge clk) disable iff (rst) exp_valid |-> slot_out.inst == exp_slot.inst)
    else begin
        value_errors++;
        $display("ERR %0t slot_out.inst exp %h got %h", $time, $sampled(exp_slot.inst),
                 $sampled(slot_out.inst));
    end

    assert property (@(posedge clk) disable iff (rst) exp_valid |-> slot_out.pc == exp_slot.pc)
    else begin
        value_errors++;
        $display("ERR %0t slot_out.pc exp %h got %h", $time, $sampled(exp_slot.pc),
                 $sampled(slot_out.pc));
    end

    assert property (@(posedge clk) disable iff (rst)
                     exp_valid |-> slot_out.predict_jump == exp_slot.predict_jump)
    else begin
        value_errors++;
        $display("ERR %0t slot_out.predict_jump exp %b got %b", $time,
                 $sampled(exp_slot.predict_jump), $sampled(slot_out.predict_jump));
    end

    assert property (@(posedge clk) disable iff (rst) exp_valid |-> is_c_extend == exp_c)
    else begin
        value_errors++;
        $display("ERR %0t is_c_extend exp %b got %b", $time, $sampled(exp_c),
                 $sampled(is_c_extend));
    end

    initial begin
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] c;
        rst        = 1'b1;
        rdy        = 1'b0;
        rollback   = 1'b0;
        inst_valid = 1'b0;
        slot_in    = '0;
        lfsr_state = 32'h95b4;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        wait_drain(4);

        // full-width words pass straight through
        for (int i = 0; i < 40; i++) begin
            draw_bits(30, r);
            drive_item({r[29:0], 2'b11}, 1'b1, 1'b1, 1'b0);
        end

        // all 25 forms back to back
        for (int rep = 0; rep < 6; rep++) begin
            for (int k = 0; k < 25; k++) begin
                draw_bits(16, hi);
                draw_bits(16, r);
                drive_item({hi[15:0], make_form(k, r[15:0])}, 1'b1, 1'b1, 1'b0);
            end
        end

        // unlisted patterns expand to zero
        for (int k = 0; k < 15; k++) begin
            draw_bits(16, r);
            drive_item({16'h0, make_illegal(k, r[15:0])}, 1'b1, 1'b1, 1'b0);
        end

        // rdy low and rollback high mixed in with idle cycles
        for (int i = 0; i < 80; i++) begin
            draw_bits(4, c);
            draw_bits(32, r);
            drive_item(r, c[3] | c[2], c[0] | c[1], c[2] & c[1]);
        end

        // reset while items keep arriving
        draw_bits(32, r);
        drive_item(r, 1'b1, 1'b1, 1'b0);
        rst <= 1'b1;
        draw_bits(32, r);
        drive_item(r, 1'b1, 1'b1, 1'b0);
        rst <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            draw_bits(32, r);
            drive_item(r, 1'b1, 1'b1, 1'b0);
        end

        drive_item(32'h0, 1'b0, 1'b1, 1'b0);
        wait_drain(8);
        repeat (2) @(posedge clk);

        if (checked == 0) begin
            $display("no output item was checked");
        end
        $display("errors: %0d value, %0d timeout, %0d items checked", value_errors,
                 timeout_errors, checked);
        if (value_errors == 0 && timeout_errors == 0 && checked > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+bench
logic/rvc_pkg.sv
logic/rvc_field_decode.sv
logic/rvc_imm_unscramble.sv
logic/rvc_rv32_encode.sv
logic/rvc_expand_ctrl.sv
logic/rvc_expander.sv
bench/rvc_expander_tb.sv

//--- Bender.yml
package:
  name: rvc_expander

sources:
  - logic/rvc_pkg.sv
  - logic/rvc_field_decode.sv
  - logic/rvc_imm_unscramble.sv
  - logic/rvc_rv32_encode.sv
  - logic/rvc_expand_ctrl.sv
  - logic/rvc_expander.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rvc_expander_tb.sv
